// File: project.f
+incdir+.
sdmacPkg.sv
regDecode.sv
byteSequencer.sv
dataFifo.sv
hostWordPort.sv
sdmacTop.sv
sdmac_asserts.sv
tbSdmac.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SCSI DMA inbound path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tbSdmac -o simSdmac
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simSdmac)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1

// File: tbSdmac.sv
/* Directed testbench for sdmacTop with clock, reset, packing model,
   host monitor, one task per behavior and the closing summary */

`timescale 1ns/10ps
`include "sdmac_params.svh"

module tbSdmac import sdmacPkg::*; ();

    logic       ACR_WR;
    logic       nRST_FIFO;
    regWrite_t  regIn;
    logic       regValid;
    logic       regReady;
    logic [7:0] byteIn;
    logic       byteValid;
    logic       byteReady;
    hostWord_t  hostOut;
    logic       hostValid;
    logic       hostReady = 1'b0;
    logic       readyHold = 1'b0;   // Host ready level outside random mode
    logic       randMode = 1'b0;
    integer     seed = 6553;
    int         errors = 0;
    int         testsRun = 0;
    int         wordsSeen = 0;
    hostWord_t  expQ[$];            // Expected host words in order
    logic [1:0] modelPtr;           // Model of the next lane
    logic [31:0] modelData;
    logic [3:0] modelMask;          // Bit 3 is lane 0

    sdmacTop u_dut (.*);

    always #2 ACR_WR = ~ACR_WR;

    // Host ready driver that is random or held
    always @(negedge ACR_WR) begin
        hostReady <= randMode ? 1'($random(seed)) : readyHold;
    end

    // Compare every host handshake with the model queue
    always @(posedge ACR_WR) begin
        if (nRST_FIFO && hostValid && hostReady) begin
            assert (expQ.size() != 0) else begin
                $display("Host delivered a word that was not expected at %0t", $time);
                errors++;
            end
            if (expQ.size() != 0) begin
                assert (hostOut == expQ[0]) else begin
                    $display("Fail at %0t: got %h/%b, expected %h/%b", $time, hostOut.data,
                             hostOut.byteEn, expQ[0].data, expQ[0].byteEn);
                    errors++;
                end
                void'(expQ.pop_front());
            end
            wordsSeen++;
        end
    end

    // Packing rule with lane 0 in bits 31:24 and a commit after lane 3
    function automatic void modelByte(input logic [7:0] b);
        hostWord_t w;
        modelData[8*(3-modelPtr) +: 8] = b;
        modelMask[3-modelPtr] = 1'b1;
        if (modelPtr == 2'd3) begin
            w.data   = modelData;
            w.byteEn = modelMask;
            expQ.push_back(w);
            modelData = '0;
            modelMask = '0;
        end
        modelPtr = modelPtr + 2'd1;
    endfunction

    function automatic void modelFlush();
        hostWord_t w;
        if (modelMask != 4'b0000) begin
            w.data   = modelData;
            w.byteEn = modelMask;
            expQ.push_back(w);
        end
        modelData = '0;
        modelMask = '0;
        modelPtr  = 2'd0;
    endfunction

    task automatic sendByte(input logic [7:0] b, output bit stalled);
        int n;
        n = 0;
        stalled = 1'b0;
        @(negedge ACR_WR);
        byteIn    = b;
        byteValid = 1'b1;
        while (!byteReady && n < `WAIT_LIMIT) begin
            stalled   = 1'b1;
            readyHold = 1'b1;   // Let the host drain
            @(negedge ACR_WR);
            n++;
        end
        if (!byteReady) begin
            $display("Timed out waiting for byteReady at %0t", $time);
            errors++;
        end else begin
            @(posedge ACR_WR);
            modelByte(b);
        end
        @(negedge ACR_WR);
        byteValid = 1'b0;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(negedge ACR_WR);
        regIn    = '{addr: addr, data: data};
        regValid = 1'b1;
        while (!regReady && n < `WAIT_LIMIT) begin
            @(negedge ACR_WR);
            n++;
        end
        if (!regReady) begin
            $display("Timed out waiting for regReady at %0t", $time);
            errors++;
        end
        @(posedge ACR_WR);
        if (addr == `FLUSH_OFFSET) modelFlush();
        if (addr == `ACR_OFFSET) modelPtr = data[1:0];
        @(negedge ACR_WR);
        regValid = 1'b0;
        n = 0;
        // Command must reach the sequencer before more bytes
        while (u_dut.u_decode.cmdValid && n < `WAIT_LIMIT) begin
            @(negedge ACR_WR);
            n++;
        end
        if (u_dut.u_decode.cmdValid) begin
            $display("Command never left the register decoder at %0t", $time);
            errors++;
        end
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while ((expQ.size() != 0 || hostValid) && n < `WAIT_LIMIT) begin
            @(negedge ACR_WR);
            n++;
        end
        if (expQ.size() != 0 || hostValid) begin
            $display("Timed out with %0d words not delivered and the host port busy",
                     expQ.size());
            errors++;
            expQ.delete();
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "errors");
    endtask

    task automatic alignedTest();
        int e0;
        bit st;
        e0 = errors;
        readyHold = 1'b1;
        for (int i = 0; i < 8; i++) sendByte(8'h10 + 8'(i), st);
        waitDrain();
        finishTest("aligned packing", e0);
    endtask

    task automatic offsetTest();
        int e0;
        bit st;
        e0 = errors;
        writeReg(`ACR_OFFSET, 32'd2);
        for (int i = 0; i < 6; i++) sendByte(8'hA0 + 8'(i), st);
        waitDrain();
        finishTest("start offset", e0);
    endtask

    task automatic flushTest();
        int e0;
        bit st;
        e0 = errors;
        for (int i = 0; i < 3; i++) sendByte(8'h51 + 8'(i), st);
        writeReg(`FLUSH_OFFSET, 32'd0);
        waitDrain();
        writeReg(`FLUSH_OFFSET, 32'd0);  // Nothing pending
        for (int i = 0; i < 20; i++) begin
            @(negedge ACR_WR);
            assert (!hostValid) else begin
                $display("Fail at %0t: empty flush produced a word", $time);
                errors++;
            end
        end
        finishTest("flush", e0);
    endtask

    task automatic ignoredRegTest();
        int e0;
        bit st;
        e0 = errors;
        writeReg(8'h20, 32'hFFFF_FFFF);  // Idle slot, a start lane would apply at once
        sendByte(8'hC1, st);
        sendByte(8'hC2, st);
        writeReg(8'h20, 32'hFFFF_FFFF);
        sendByte(8'hC3, st);
        sendByte(8'hC4, st);
        waitDrain();
        finishTest("ignored register", e0);
    endtask

    task automatic backPressureTest();
        int e0;
        bit st;
        bit sawStall;
        e0 = errors;
        sawStall = 1'b0;
        readyHold = 1'b0;
        repeat (2) @(negedge ACR_WR);
        for (int i = 0; i < 48; i++) begin
            sendByte(8'(i * 5 + 3), st);
            sawStall |= st;
        end
        readyHold = 1'b1;
        waitDrain();
        assert (sawStall) else begin
            $display("Fail at %0t: byteReady never dropped", $time);
            errors++;
        end
        finishTest("back-pressure", e0);
    endtask

    task automatic randomTest();
        int e0;
        int r;
        bit st;
        e0 = errors;
        randMode = 1'b1;
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) writeReg(`FLUSH_OFFSET, 32'd0);
            else sendByte(r[15:8], st);
        end
        writeReg(`FLUSH_OFFSET, 32'd0);
        randMode  = 1'b0;
        readyHold = 1'b1;
        waitDrain();
        finishTest("random traffic", e0);
    endtask

    initial begin
        ACR_WR    = 1'b0;
        nRST_FIFO = 1'b0;
        regIn     = '0;
        regValid  = 1'b0;
        byteIn    = 8'h00;
        byteValid = 1'b0;
        modelPtr  = 2'd0;
        modelData = '0;
        modelMask = '0;
        repeat (16) @(posedge ACR_WR);
        @(negedge ACR_WR);
        nRST_FIFO = 1'b1;
        alignedTest();
        offsetTest();
        flushTest();
        ignoredRegTest();
        backPressureTest();
        randomTest();
        $display("Tests %0d, words %0d, errors %0d", testsRun, wordsSeen, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sdmac_asserts.sv
/* Bound checker for FIFO commit, occupancy and host port stability */

`timescale 1ns/10ps

module sdmacAsserts import sdmacPkg::*; (
    input logic       ACR_WR,
    input logic       nRST_FIFO,
    input logic       push,       // Word commit into the FIFO
    input logic       fifoFull,
    input logic [3:0] count,
    input logic       hostValid,
    input logic       hostReady,
    input hostWord_t  hostOut
);

    noCommitWhenFull: assert property (@(posedge ACR_WR) disable iff (!nRST_FIFO)
        !(push && fifoFull)) else $error("Word committed into a full FIFO");

    countInRange: assert property (@(posedge ACR_WR) disable iff (!nRST_FIFO)
        count <= 4'd8) else $error("FIFO occupancy above eight");

    // Stalled host keeps the same word on the port
    holdWhileStalled: assert property (@(posedge ACR_WR) disable iff (!nRST_FIFO)
        hostValid && !hostReady |=> hostValid && $stable(hostOut))
        else $error("Host word changed during a stall");

endmodule

bind dataFifo sdmacAsserts u_fifoChk (
    .ACR_WR, .nRST_FIFO, .push(laneWr.commit), .fifoFull, .count,
    .hostValid(1'b0), .hostReady(1'b0), .hostOut('0)
);

bind hostWordPort sdmacAsserts u_hostChk (
    .ACR_WR, .nRST_FIFO, .push(1'b0), .fifoFull(1'b0), .count(4'd0),
    .hostValid, .hostReady, .hostOut
);

// File: sdmacTop.sv
/* Inbound SCSI DMA data path: decoder, sequencer, FIFO and host port */

`timescale 1ns/10ps

module sdmacTop import sdmacPkg::*; (
    input  logic       ACR_WR,
    input  logic       nRST_FIFO,
    input  regWrite_t  regIn,
    input  logic       regValid,
    output logic       regReady,
    input  logic [7:0] byteIn,
    input  logic       byteValid,
    output logic       byteReady,
    output hostWord_t  hostOut,
    output logic       hostValid,
    input  logic       hostReady
);

    seqCmd_t    cmd;         // Decoder to sequencer
    logic       cmdValid;
    logic       cmdReady;
    laneWrite_t laneWr;      // Sequencer to FIFO
    logic       laneWrEn;
    logic       fifoFull;
    logic       fifoEmpty;
    hostWord_t  head;        // FIFO to host port
    logic       popEn;

    regDecode u_decode (
        .ACR_WR, .nRST_FIFO, .regIn, .regValid, .regReady,
        .cmd, .cmdValid, .cmdReady
    );

    byteSequencer u_seq (
        .ACR_WR, .nRST_FIFO, .byteIn, .byteValid, .byteReady,
        .cmd, .cmdValid, .cmdReady, .laneWr, .laneWrEn, .fifoFull
    );

    dataFifo u_fifo (
        .ACR_WR, .nRST_FIFO, .laneWr, .laneWrEn, .popEn,
        .head, .fifoFull, .fifoEmpty
    );

    hostWordPort u_host (
        .ACR_WR, .nRST_FIFO, .head, .fifoEmpty, .popEn,
        .hostOut, .hostValid, .hostReady
    );

endmodule

// File: hostWordPort.sv
/* Host output register, holds the FIFO head toward the host */

`timescale 1ns/10ps

module hostWordPort import sdmacPkg::*; (
    input  logic      ACR_WR,
    input  logic      nRST_FIFO,
    input  hostWord_t head,
    input  logic      fifoEmpty,
    output logic      popEn,
    output hostWord_t hostOut,
    output logic      hostValid,
    input  logic      hostReady
);

    logic loadEn;

    // Refill when empty or drained this cycle
    assign loadEn = !fifoEmpty && (!hostValid || hostReady);
    assign popEn  = loadEn;  // Pop in step with the load

    always_ff @(posedge ACR_WR or negedge nRST_FIFO) begin
        if (!nRST_FIFO) begin
            hostValid <= 1'b0;
        end else if (loadEn) begin
            hostValid <= 1'b1;
        end else if (hostReady) begin
            hostValid <= 1'b0;  // Word taken, nothing behind it
        end
    end

    // Held while the host stalls
    always_ff @(posedge ACR_WR) begin
        if (loadEn) begin
            hostOut <= head;
        end
    end

endmodule

// File: dataFifo.sv
/* Eight-entry word FIFO with byte-lane writes and per-entry lane masks */

`timescale 1ns/10ps
`include "sdmac_params.svh"

module dataFifo import sdmacPkg::*; (
    input  logic       ACR_WR,
    input  logic       nRST_FIFO,
    input  laneWrite_t laneWr,
    input  logic       laneWrEn,
    input  logic       popEn,
    output hostWord_t  head,
    output logic       fifoFull,
    output logic       fifoEmpty
);

    localparam logic [`CNT_W-1:0] CountFull = `FIFO_DEPTH;
    localparam logic [`CNT_W-1:0] CountLast = `FIFO_DEPTH - 1;

    logic [31:0]       wordMem  [`FIFO_DEPTH];
    logic [3:0]        laneMask [`FIFO_DEPTH];  // Bit 3 is lane 0
    logic [`PTR_W-1:0] wrPtr;
    logic [`PTR_W-1:0] rdPtr;
    logic [`PTR_W-1:0] wrNext;
    logic [`CNT_W-1:0] count;
    logic [1:0]        bytePos;   // Byte position in the word, 3 is bits 31:24
    logic              push;
    logic              nextHeld;  // Entry after wrPtr still holds a word

    assign bytePos  = 2'd3 - laneWr.lane;
    assign push     = laneWr.commit;
    assign wrNext   = wrPtr + 1'b1;
    assign nextHeld = (count == CountLast) && !popEn;

    // Byte lane strobes into the entry at the write pointer
    always_ff @(posedge ACR_WR) begin
        if (laneWrEn) begin
            wordMem[wrPtr][{bytePos, 3'b000} +: 8] <= laneWr.data;
        end
    end

    // Lane-valid masks
    always_ff @(posedge ACR_WR or negedge nRST_FIFO) begin
        if (!nRST_FIFO) begin
            for (int i = 0; i < `FIFO_DEPTH; i++) begin
                laneMask[i] <= 4'b0000;
            end
        end else begin
            if (laneWrEn) begin
                laneMask[wrPtr][bytePos] <= 1'b1;
            end
            // Fresh slot for the next word, unless it is still the head
            if (push && !nextHeld) begin
                laneMask[wrNext] <= 4'b0000;
            end
            // Head freed while full becomes the next write slot
            if (popEn && fifoFull) begin
                laneMask[rdPtr] <= 4'b0000;
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ACR_WR or negedge nRST_FIFO) begin
        if (!nRST_FIFO) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrNext;
            end
            if (popEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

    // Head read, unwritten lanes forced to zero
    always_comb begin
        head.byteEn = laneMask[rdPtr];
        for (int b = 0; b < 4; b++) begin
            head.data[8*b +: 8] = laneMask[rdPtr][b] ? wordMem[rdPtr][8*b +: 8] : 8'h00;
        end
    end

    assign fifoFull  = (count == CountFull);
    assign fifoEmpty = (count == '0);

endmodule

// File: byteSequencer.sv
/* Byte sequencer: byte pointer, lane steering, word commit on lane 3 or flush */

`timescale 1ns/10ps

module byteSequencer import sdmacPkg::*; (
    input  logic       ACR_WR,
    input  logic       nRST_FIFO,
    input  logic [7:0] byteIn,
    input  logic       byteValid,
    output logic       byteReady,
    input  seqCmd_t    cmd,
    input  logic       cmdValid,
    output logic       cmdReady,
    output laneWrite_t laneWr,
    output logic       laneWrEn,
    input  logic       fifoFull
);

    seqState_e  state;
    logic [1:0] bytePtr;     // Lane for the next byte
    logic [1:0] pendOffset;  // Offset held for the next slot
    logic       pendValid;
    logic       byteAcc;
    logic       flushAcc;
    logic       setAcc;
    logic       slotOpen;    // Slot has a lane written after this cycle
    logic       commitNow;

    assign byteReady = !fifoFull;
    assign byteAcc   = byteValid && byteReady;

    // Flush stalls only when a partial word cannot be pushed
    assign cmdReady = !(cmd.op == cmdFlush && fifoFull && state == stFilling);
    assign flushAcc = cmdValid && cmdReady && (cmd.op == cmdFlush);
    assign setAcc   = cmdValid && cmdReady && (cmd.op == cmdSetOffset);

    assign slotOpen  = (state == stFilling) || byteAcc;
    assign commitNow = (byteAcc && bytePtr == 2'd3) || (flushAcc && slotOpen);

    // Lane write toward the FIFO, same cycle as the byte handshake
    always_comb begin
        laneWr.lane   = bytePtr;
        laneWr.data   = byteIn;
        laneWr.commit = commitNow;  // Without byteAcc this is commit-only
    end
    assign laneWrEn = byteAcc;      // Byte strobe

    always_ff @(posedge ACR_WR or negedge nRST_FIFO) begin
        if (!nRST_FIFO) begin
            state      <= stIdle;
            bytePtr    <= 2'd0;
            pendOffset <= 2'd0;
            pendValid  <= 1'b0;
        end else if (commitNow) begin
            state     <= stIdle;
            pendValid <= 1'b0;
            // New slot starts at the latest requested offset, else lane 0
            bytePtr <= setAcc ? cmd.offset : (pendValid ? pendOffset : 2'd0);
        end else begin
            if (byteAcc) begin
                bytePtr <= bytePtr + 2'd1;
                state   <= stFilling;
            end
            if (setAcc && slotOpen) begin
                pendOffset <= cmd.offset;   // Deferred to next slot
                pendValid  <= 1'b1;
            end else if (setAcc) begin
                bytePtr <= cmd.offset;      // Idle, applies at once
            end
        end
    end

endmodule

// File: regDecode.sv
/* Host register decoder, turns ACR and flush writes into sequencer commands */

`timescale 1ns/10ps
`include "sdmac_params.svh"

module regDecode import sdmacPkg::*; (
    input  logic      ACR_WR,
    input  logic      nRST_FIFO,
    input  regWrite_t regIn,
    input  logic      regValid,
    output logic      regReady,
    output seqCmd_t   cmd,
    output logic      cmdValid,
    input  logic      cmdReady
);

    logic regAcc;   // Write taken this cycle
    logic hitAcr;
    logic hitFlush;

    // Output slot is free, or it empties this cycle
    assign regReady = !cmdValid || cmdReady;
    assign regAcc   = regValid && regReady;

    assign hitAcr   = (regIn.addr == `ACR_OFFSET);
    assign hitFlush = (regIn.addr == `FLUSH_OFFSET);

    // Command valid flag
    always_ff @(posedge ACR_WR or negedge nRST_FIFO) begin
        if (!nRST_FIFO) begin
            cmdValid <= 1'b0;
        end else if (regAcc) begin
            cmdValid <= hitAcr || hitFlush; // Other offsets just consumed
        end else if (cmdReady) begin
            cmdValid <= 1'b0;               // Taken by the sequencer
        end
    end

    // Command payload
    always_ff @(posedge ACR_WR) begin
        if (regAcc && hitAcr) begin
            cmd.op     <= cmdSetOffset;
            cmd.offset <= regIn.data[1:0];  // Starting byte lane
        end else if (regAcc && hitFlush) begin
            cmd.op     <= cmdFlush;
            cmd.offset <= 2'd0;
        end
    end

endmodule

// File: sdmacPkg.sv
/* Shared types: sequencer opcodes and states, bus and FIFO structs */

package sdmacPkg;

    // Commands from the register decoder to the byte sequencer
    typedef enum logic [1:0] {
        cmdSetOffset = 2'd0,  // Load start lane
        cmdFlush     = 2'd1   // Close a partial word
    } cmdOp_e;

    // Sequencer slot state
    typedef enum logic {
        stIdle,     // No lane written in the current slot
        stFilling   // At least one lane written
    } seqState_e;

    typedef struct packed {
        logic [7:0]  addr;  // Register offset
        logic [31:0] data;
    } regWrite_t;

    typedef struct packed {
        cmdOp_e     op;
        logic [1:0] offset; // Start lane for cmdSetOffset
    } seqCmd_t;

    typedef struct packed {
        logic [1:0] lane;   // 0 is bits 31:24
        logic [7:0] data;
        logic       commit; // Slot closes after this write
    } laneWrite_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  byteEn; // Bit 3 is lane 0
    } hostWord_t;

endpackage

// File: sdmac_params.svh
/* FIFO sizing, host register offsets and the testbench wait limit */

`ifndef SDMAC_PARAMS_SVH
`define SDMAC_PARAMS_SVH

// FIFO geometry
`define FIFO_DEPTH 8       // Word entries
`define PTR_W 3            // Read/write pointer width
`define CNT_W 4            // Occupancy count, 0 to 8

// Host register map
`define ACR_OFFSET 8'h0C   // ACR, low bits give the start lane
`define FLUSH_OFFSET 8'h14 // Flush a partly filled word

// Bound for every wait loop in the testbench
`define WAIT_LIMIT 200

`endif
